//--- source/cpu_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// rv32i integer core shared types
// opcodes, alu codes and pipeline structs
// ~~~~~~~~~~~~~~~~~~~~

package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_adr_t;
	typedef logic [2:0]  funct3_t;

	// major opcodes kept by this core
	localparam logic [6:0] OPC_OP    = 7'b0110011;
	localparam logic [6:0] OPC_OPIMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI   = 7'b0110111;

	localparam funct3_t F3_ADD  = 3'b000; // add, sub
	localparam funct3_t F3_SLL  = 3'b001;
	localparam funct3_t F3_SLT  = 3'b010;
	localparam funct3_t F3_SLTU = 3'b011;
	localparam funct3_t F3_XOR  = 3'b100;
	localparam funct3_t F3_SR   = 3'b101; // srl, sra
	localparam funct3_t F3_OR   = 3'b110;
	localparam funct3_t F3_AND  = 3'b111;

	// decode to execute
	typedef struct packed {
		logic     valid;
		logic     wbk;      // writes rd
		logic     lui;
		logic     use_imm;
		logic     alt;      // sub or sra
		funct3_t  funct3;
		reg_adr_t rd;
		reg_adr_t rs1;
		reg_adr_t rs2;
		word_t    rs1_data;
		word_t    rs2_data;
		word_t    imm;
	} ex_cmd_t;

	// register write
	typedef struct packed {
		logic     valid;
		reg_adr_t rd;
		word_t    data;
	} wb_t;

endpackage

//--- source/cpu_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// rv32i integer core top
// decode, register file, forwarding, execute
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cpu_top import cpu_pkg::*; (
	input  logic     clk,
	input  logic     i_rst,

	input  logic     i_inst_valid,
	input  word_t    i_inst,

	output logic     o_wb_valid,
	output reg_adr_t o_wb_rd,
	output word_t    o_wb_data,

	input  reg_adr_t i_rf_radr_mon,
	output word_t    o_rf_rdata_mon
);

reg_adr_t rs1_adr;
reg_adr_t rs2_adr;
word_t    rs1_data;
word_t    rs2_data;
word_t    rs1_val;
word_t    rs2_val;
ex_cmd_t  cmd;
wb_t      wb;

id_stage i_id_stage (
	.clk          (clk),
	.i_rst        (i_rst),
	.i_inst_valid (i_inst_valid),
	.i_inst       (i_inst),
	.o_rs1_adr    (rs1_adr),
	.o_rs2_adr    (rs2_adr),
	.i_rs1_data   (rs1_data),
	.i_rs2_data   (rs2_data),
	.o_cmd        (cmd)
);

reg_file i_reg_file (
	.clk            (clk),
	.i_rst          (i_rst),
	.i_rs1_adr      (rs1_adr),
	.i_rs2_adr      (rs2_adr),
	.o_rs1_data     (rs1_data),
	.o_rs2_data     (rs2_data),
	.i_wb           (wb),
	.i_rf_radr_mon  (i_rf_radr_mon),
	.o_rf_rdata_mon (o_rf_rdata_mon)
);

forwarding i_forwarding (
	.clk       (clk),
	.i_rst     (i_rst),
	.i_cmd     (cmd),
	.i_wb      (wb),
	.o_rs1_val (rs1_val),
	.o_rs2_val (rs2_val)
);

ex_stage i_ex_stage (
	.clk       (clk),
	.i_rst     (i_rst),
	.i_cmd     (cmd),
	.i_rs1_val (rs1_val),
	.i_rs2_val (rs2_val),
	.o_wb      (wb)
);

assign o_wb_valid = wb.valid;
assign o_wb_rd    = wb.rd;
assign o_wb_data  = wb.data;

endmodule

//--- source/ex_stage.sv
// ~~~~~~~~~~~~~~~~~~~~
// execute stage
// alu and write-back register
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module ex_stage import cpu_pkg::*; (
	input  logic    clk,
	input  logic    i_rst,

	input  ex_cmd_t i_cmd,
	input  word_t   i_rs1_val,
	input  word_t   i_rs2_val,

	output wb_t     o_wb
);

word_t      op1;
word_t      op2;
logic [4:0] shamt;
word_t      alu;
word_t      result;
wb_t        wb_nxt;
wb_t        wb_q;

assign op1   = i_rs1_val;
assign op2   = i_cmd.use_imm ? i_cmd.imm : i_rs2_val;
assign shamt = op2[4:0];

always_comb begin
	case (i_cmd.funct3)
		F3_ADD: begin
			if (i_cmd.alt)
				alu = op1 - op2;
			else
				alu = op1 + op2;
		end
		F3_SLL:  alu = op1 << shamt;
		F3_SLT:  alu = {31'b0, $signed(op1) < $signed(op2)};
		F3_SLTU: alu = {31'b0, op1 < op2}; // imm already sign-extended
		F3_XOR:  alu = op1 ^ op2;
		F3_SR: begin
			if (i_cmd.alt)
				alu = $signed(op1) >>> shamt;
			else
				alu = op1 >> shamt;
		end
		F3_OR:   alu = op1 | op2;
		F3_AND:  alu = op1 & op2;
		default: alu = '0;
	endcase
end

assign result = i_cmd.lui ? i_cmd.imm : alu; // lui passes the upper imm

always_comb begin
	wb_nxt.valid = i_cmd.valid & i_cmd.wbk;
	wb_nxt.rd    = i_cmd.rd;
	wb_nxt.data  = result;
end

always_ff @(posedge clk) begin
	wb_q <= wb_nxt;
	if (i_rst)
		wb_q.valid <= 1'b0;
end

assign o_wb = wb_q;

endmodule

//--- source/forwarding.sv
// ~~~~~~~~~~~~~~~~~~~~
// operand forwarding
// newest of current wb, older wb, register data
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module forwarding import cpu_pkg::*; (
	input  logic    clk,
	input  logic    i_rst,

	input  ex_cmd_t i_cmd,
	input  wb_t     i_wb,

	output word_t   o_rs1_val,
	output word_t   o_rs2_val
);

// previous write, already in the rf but missed by the decode read
wb_t wb_old;

function automatic logic hit(wb_t w, reg_adr_t rs);
	return w.valid && (w.rd == rs) && (w.rd != '0);
endfunction

function automatic word_t pick(wb_t cur, wb_t old, reg_adr_t rs, word_t rf_data);
	word_t val;
	if (hit(cur, rs))
		val = cur.data;
	else if (hit(old, rs))
		val = old.data;
	else
		val = rf_data;
	return val;
endfunction

always_ff @(posedge clk) begin
	if (i_wb.valid)
		wb_old <= i_wb;
	if (i_rst)
		wb_old.valid <= 1'b0;
end

assign o_rs1_val = pick(i_wb, wb_old, i_cmd.rs1, i_cmd.rs1_data);
assign o_rs2_val = pick(i_wb, wb_old, i_cmd.rs2, i_cmd.rs2_data);

endmodule

//--- source/id_stage.sv
// ~~~~~~~~~~~~~~~~~~~~
// decode stage
// classifies the word and registers the command
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module id_stage import cpu_pkg::*; (
	input  logic     clk,
	input  logic     i_rst,

	input  logic     i_inst_valid,
	input  word_t    i_inst,

	output reg_adr_t o_rs1_adr,
	output reg_adr_t o_rs2_adr,
	input  word_t    i_rs1_data,
	input  word_t    i_rs2_data,

	output ex_cmd_t  o_cmd
);

logic [6:0] opcode;
funct3_t    funct3;
reg_adr_t   rd;
reg_adr_t   rs1;
reg_adr_t   rs2;
logic       is_op;
logic       is_opimm;
logic       is_lui;
logic       alt;
word_t      imm;
ex_cmd_t    cmd_nxt;
ex_cmd_t    cmd_q;

// instruction fields
assign opcode = i_inst[6:0];
assign rd     = i_inst[11:7];
assign funct3 = i_inst[14:12];
assign rs1    = i_inst[19:15];
assign rs2    = i_inst[24:20];

assign is_op    = (opcode == OPC_OP);
assign is_opimm = (opcode == OPC_OPIMM);
assign is_lui   = (opcode == OPC_LUI);

// bit 30 only matters for sub, sra and srai
assign alt = i_inst[30] & ((is_op & ((funct3 == F3_ADD) | (funct3 == F3_SR)))
	| (is_opimm & (funct3 == F3_SR)));

always_comb begin
	if (is_lui)
		imm = {i_inst[31:12], 12'b0};
	else
		imm = {{20{i_inst[31]}}, i_inst[31:20]}; // i-type, shamt in low bits
end

assign o_rs1_adr = rs1;
assign o_rs2_adr = rs2;

always_comb begin
	cmd_nxt.valid    = i_inst_valid;
	cmd_nxt.wbk      = (is_op | is_opimm | is_lui) & (rd != '0);
	cmd_nxt.lui      = is_lui;
	cmd_nxt.use_imm  = is_opimm;
	cmd_nxt.alt      = alt;
	cmd_nxt.funct3   = funct3;
	cmd_nxt.rd       = rd;
	cmd_nxt.rs1      = rs1;
	cmd_nxt.rs2      = rs2;
	cmd_nxt.rs1_data = i_rs1_data;
	cmd_nxt.rs2_data = i_rs2_data;
	cmd_nxt.imm      = imm;
end

always_ff @(posedge clk) begin
	cmd_q <= cmd_nxt;
	if (i_rst)
		cmd_q.valid <= 1'b0;
end

assign o_cmd = cmd_q;

endmodule

//--- source/reg_file.sv
// ~~~~~~~~~~~~~~~~~~~~
// 32 x 32 register file with monitor read
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
	input  logic     clk,
	input  logic     i_rst,

	input  reg_adr_t i_rs1_adr,
	input  reg_adr_t i_rs2_adr,
	output word_t    o_rs1_data,
	output word_t    o_rs2_data,

	input  wb_t      i_wb,

	input  reg_adr_t i_rf_radr_mon,
	output word_t    o_rf_rdata_mon
);

word_t regs [32];
word_t rdata_mon;

always_ff @(posedge clk) begin
	if (i_rst) begin
		for (int i = 0; i < 32; i++)
			regs[i] <= '0;
	end else if (i_wb.valid && (i_wb.rd != '0)) begin // x0 stays zero
		regs[i_wb.rd] <= i_wb.data;
	end
end

// no write-through, forwarding covers it
assign o_rs1_data = regs[i_rs1_adr];
assign o_rs2_data = regs[i_rs2_adr];

always_ff @(posedge clk) begin
	rdata_mon <= regs[i_rf_radr_mon];
end

assign o_rf_rdata_mon = rdata_mon;

endmodule

//--- test/cpu_assert.sv
// ~~~~~~~~~~~~~~~~~~~~
// write-back port checks bound to cpu_top
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cpu_assert import cpu_pkg::*; (
	input logic     clk,
	input logic     i_rst,
	input logic     i_inst_valid,
	input logic     o_wb_valid,
	input reg_adr_t o_wb_rd
);

int err_cnt = 0;

a_wb_in_rst: assert property (@(posedge clk) i_rst |=> !o_wb_valid)
	else begin
		$error("write-back valid while in reset");
		err_cnt++;
	end
a_wb_rd_nz: assert property (@(posedge clk) disable iff (i_rst) o_wb_valid |-> o_wb_rd != '0)
	else begin
		$error("write-back to x0");
		err_cnt++;
	end
a_wb_src: assert property (@(posedge clk) disable iff (i_rst)
	o_wb_valid |-> $past(i_inst_valid, 2))
	else begin
		$error("write-back without an instruction two cycles earlier");
		err_cnt++;
	end

endmodule

bind cpu_top cpu_assert i_cpu_assert (.*);

//--- test/cpu_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// rv32i core testbench
// random instructions checked against a model
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

localparam int RST_CYCLES  = 16;
localparam int STIM_CYCLES = 64 + 440 + 1625 + 225 + 64; // sum of the tests with drains
localparam int MAX_CYCLES  = 3 * (STIM_CYCLES + RST_CYCLES);

logic        clk;
logic        i_rst;
logic        i_inst_valid;
word_t       i_inst;
logic        o_wb_valid;
reg_adr_t    o_wb_rd;
word_t       o_wb_data;
reg_adr_t    i_rf_radr_mon;
word_t       o_rf_rdata_mon;
int          cyc = 0;
int          errors;
int          test_err;
logic [31:0] lcg;
word_t       model_rf [32];
reg_adr_t    exp_rd [$];
word_t       exp_data [$];
int          exp_cyc [$];

cpu_top i_cpu_top (.*);

initial begin
	clk = 1'b0;
	forever #2 clk = ~clk;
end

always @(posedge clk)
	cyc <= cyc + 1;

initial begin
	wait (cyc >= MAX_CYCLES);
	$display("timeout, run stopped after %0d cycles", cyc);
	$display("TEST FAILED");
	$finish;
end

function automatic logic [15:0] rnd16();
	lcg = lcg * 32'd1103515245 + 32'd12345;
	return lcg[31:16]; // upper bits have the longer period
endfunction

function automatic int rnd_below(int n);
	return rnd16() % n;
endfunction

function automatic word_t rnd_word();
	return {rnd16(), rnd16()};
endfunction

function automatic reg_adr_t rnd_reg();
	return reg_adr_t'(rnd_below(8)); // x0..x7 for dense dependencies
endfunction

function automatic word_t op_inst(funct3_t f3, logic alt, reg_adr_t rd, reg_adr_t rs1,
	reg_adr_t rs2);
	return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic word_t imm_inst(funct3_t f3, logic [11:0] imm, reg_adr_t rd, reg_adr_t rs1);
	return {imm, rs1, f3, rd, OPC_OPIMM};
endfunction

function automatic int error_count();
	return errors + i_cpu_top.i_cpu_assert.err_cnt;
endfunction

// reference model run at acceptance
function automatic void model_exec(word_t inst);
	logic [6:0] opc;
	funct3_t    f3;
	reg_adr_t   rd;
	word_t      a;
	word_t      b;
	word_t      r;
	opc = inst[6:0];
	f3  = inst[14:12];
	rd  = inst[11:7];
	a   = model_rf[inst[19:15]];
	b   = (opc == OPC_OP) ? model_rf[inst[24:20]] : {{20{inst[31]}}, inst[31:20]};
	if (rd == 0 || !(opc inside {OPC_OP, OPC_OPIMM, OPC_LUI}))
		return;
	case (f3)
		F3_ADD:  r = (opc == OPC_OP && inst[30]) ? a - b : a + b;
		F3_SLL:  r = a << b[4:0];
		F3_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		F3_SLTU: r = (a < b) ? 32'd1 : 32'd0;
		F3_XOR:  r = a ^ b;
		F3_SR: begin
			if (inst[30])
				r = $signed(a) >>> b[4:0];
			else
				r = a >> b[4:0];
		end
		F3_OR:   r = a | b;
		default: r = a & b;
	endcase
	if (opc == OPC_LUI)
		r = {inst[31:12], 12'b0};
	model_rf[rd] = r;
	exp_rd.push_back(rd);
	exp_data.push_back(r);
	exp_cyc.push_back(cyc + 2);
endfunction

task automatic check_eq(string name, word_t got, word_t exp);
	assert (got === exp) else begin
		$display("mismatch %s: got %h expected %h", name, got, exp);
		errors++;
	end
endtask

always @(negedge clk) begin
	if (!i_rst && o_wb_valid) begin
		assert (exp_rd.size() > 0) else begin
			$display("unexpected write-back to x%0d", o_wb_rd);
			errors++;
		end
		if (exp_rd.size() > 0) begin
			check_eq("o_wb_rd", o_wb_rd, exp_rd.pop_front());
			check_eq("o_wb_data", o_wb_data, exp_data.pop_front());
			check_eq("write-back cycle", cyc, exp_cyc.pop_front());
		end
	end
end

task automatic send(word_t inst, logic valid);
	@(posedge clk);
	#1;
	i_inst_valid = valid;
	i_inst       = inst;
	if (valid)
		model_exec(inst);
endtask

task automatic idle(int n);
	repeat (n) send(rnd_word(), 1'b0); // random word with the strobe low
endtask

task automatic drain();
	int t;
	t = 0;
	idle(1);
	while (exp_rd.size() > 0 && t < 20) begin
		@(posedge clk);
		t++;
	end
	assert (exp_rd.size() == 0) else begin
		$display("%0d expected write-backs never appeared", exp_rd.size());
		errors++;
		exp_rd.delete();
		exp_data.delete();
		exp_cyc.delete();
	end
	idle(2);
endtask

task automatic mon_read(reg_adr_t adr, output word_t data);
	word_t held;
	@(posedge clk);
	#1;
	held          = o_rf_rdata_mon;
	i_rf_radr_mon = adr;
	@(negedge clk);
	check_eq("o_rf_rdata_mon before edge", o_rf_rdata_mon, held); // still the old read
	@(posedge clk);
	#1;
	data = o_rf_rdata_mon;
endtask

task automatic check_all_regs();
	word_t d;
	for (int i = 0; i < 32; i++) begin
		mon_read(reg_adr_t'(i), d);
		check_eq($sformatf("o_rf_rdata_mon x%0d", i), d, model_rf[i]);
	end
endtask

task automatic report(int num, string name);
	$display("test %0d %s: %0d errors", num, name, error_count() - test_err);
	test_err = error_count();
endtask

initial begin
	word_t       w;
	word_t       d;
	funct3_t     f3;
	logic [11:0] imm;
	i_rst         = 1'b1;
	i_inst_valid  = 1'b0;
	i_inst        = '0;
	i_rf_radr_mon = '0;
	lcg           = 32'd72149;
	errors        = 0;
	test_err      = 0;
	for (int i = 0; i < 32; i++)
		model_rf[i] = '0;
	repeat (RST_CYCLES) @(posedge clk);
	#1;
	i_rst = 1'b0;

	check_all_regs();
	report(1, "reset state");

	for (int i = 1; i < 8; i++) begin
		w = rnd_word();
		send({w[31:12], reg_adr_t'(i), OPC_LUI}, 1'b1);
		send(imm_inst(F3_ADD, w[11:0], reg_adr_t'(i), reg_adr_t'(i)), 1'b1);
	end
	for (int i = 0; i < 400; i++) begin
		f3 = funct3_t'(rnd_below(8));
		send(op_inst(f3, (f3 == F3_ADD || f3 == F3_SR) && rnd_below(2) == 1,
			rnd_reg(), rnd_reg(), rnd_reg()), 1'b1);
	end
	drain();
	report(2, "back-to-back OP");

	for (int i = 0; i < 400; i++) begin
		w  = rnd_word();
		f3 = funct3_t'(rnd_below(8));
		if (f3 == F3_SLL)
			imm = {7'b0, w[24:20]};
		else if (f3 == F3_SR)
			imm = {1'b0, w[30], 5'b0, w[24:20]}; // srli or srai
		else
			imm = w[31:20];
		if (rnd_below(10) == 0)
			send({w[31:12], rnd_reg(), OPC_LUI}, 1'b1);
		else
			send(imm_inst(f3, imm, rnd_reg(), rnd_reg()), 1'b1);
		idle(rnd_below(4));
	end
	drain();
	report(3, "OP-IMM and LUI with gaps");

	for (int i = 0; i < 200; i++) begin
		w = rnd_word();
		case (rnd_below(4))
			0: send(op_inst(funct3_t'(rnd_below(8)), 1'b0, '0, rnd_reg(), rnd_reg()), 1'b1);
			1: send(imm_inst(funct3_t'(rnd_below(8)), w[11:0], '0, rnd_reg()), 1'b1);
			2: begin
				while (w[6:0] inside {OPC_OP, OPC_OPIMM, OPC_LUI})
					w = rnd_word();
				send(w, 1'b1); // unsupported opcode
			end
			default: send(op_inst(F3_OR, 1'b0, reg_adr_t'(rnd_below(7) + 1), '0, '0), 1'b1);
		endcase
	end
	drain();
	mon_read('0, d);
	check_eq("o_rf_rdata_mon x0", d, 32'h0);
	report(4, "rd x0 and unsupported opcodes");

	check_all_regs();
	report(5, "final register file");

	$display("tests run: 5, errors: %0d", error_count());
	if (error_count() == 0)
		$display("TEST PASSED");
	else
		$display("TEST FAILED");
	$finish;
end

endmodule

//--- vlog.f
source/cpu_pkg.sv
source/id_stage.sv
source/reg_file.sv
source/forwarding.sv
source/ex_stage.sv
source/cpu_top.sv
test/cpu_assert.sv
test/cpu_tb.sv
